//--- sync_shaper.f
sync_shaper_pkg.sv
host_cmd_decoder.sv
sync_polarity_fix.sv
csync_gen.sv
line_mark_gen.sv
sync_shaper.sv
tb_clock_gen.sv
tb_sync_shaper.sv

//--- Makefile
# Verilator flow for the sync conditioner
# Default target builds and runs the testbench, then looks for the pass line in sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module tb_sync_shaper -f sync_shaper.f
	./obj_dir/Vtb_sync_shaper | tee sim.log
	grep -q "Everything OK" sim.log

lint:
	verilator --lint-only -Wall --top-module sync_shaper \
		sync_shaper_pkg.sv host_cmd_decoder.sv sync_polarity_fix.sv \
		csync_gen.sv line_mark_gen.sv sync_shaper.sv

clean:
	rm -rf obj_dir sim.log

//--- tb_sync_shaper.sv
// Directed testbench for the sync conditioner
// Each frame has an hsync pulse at line start, vsync over the first 2 lines and DE in the middle
// Line length, pulse width, lines per frame and marker offset come from a seeded $urandom

`timescale 1ns/1ps
`default_nettype none

module tb_sync_shaper;

	import sync_shaper_pkg::*;

	localparam int CNT_W        = 16;
	localparam int V_LINES      = 2;
	localparam int TOTAL_FRAMES = 15;
	localparam int NO_MARK      = 1000;

	logic              clk_sys;
	logic              resetd;
	logic              i_cmd_active;
	logic              i_word_valid;
	logic [WORD_W-1:0] i_word_data;
	logic              o_word_ready;
	logic              i_hsync;
	logic              i_vsync;
	logic              i_de;
	logic              o_hsync;
	logic              o_vsync;
	logic              o_line_mark;

	int    line_len;
	int    pulse_len;
	int    frame_lines;
	int    mark_ofs;
	int    errors;
	int    test_errors;
	int    tests_run;
	string test_name;

	// Active-high syncs driven one cycle ago
	logic prev_h;
	logic prev_v;

	tb_clock_gen u_clk (
		.clk_sys (clk_sys),
		.resetd  (resetd)
	);

	sync_shaper #(
		.CNT_W (CNT_W)
	) DUT (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_cmd_active (i_cmd_active),
		.i_word_valid (i_word_valid),
		.i_word_data  (i_word_data),
		.o_word_ready (o_word_ready),
		.i_hsync      (i_hsync),
		.i_vsync      (i_vsync),
		.i_de         (i_de),
		.o_hsync      (o_hsync),
		.o_vsync      (o_vsync),
		.o_line_mark  (o_line_mark)
	);

	////////////////////
	// Bookkeeping

	task automatic compare(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail %s %s: expected %0d, actual %0d",
				test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic note_error(input string msg);
		$display("%s: %s", test_name, msg);
		test_errors++;
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		$display("%s finished with %0d errors", test_name, test_errors);
		errors += test_errors;
		tests_run++;
	endtask

	////////////////////
	// Stimulus

	// Opcode word then one payload word, in one active frame
	task automatic send_cmd(input logic [7:0] op, input logic [WORD_W-1:0] payload);
		logic [WORD_W-1:0] words [2];
		int                tries;
		words[0] = WORD_W'(op);
		words[1] = payload;
		@(posedge clk_sys);
		i_cmd_active <= 1'b1;
		for (int w = 0; w < 2; w++) begin
			i_word_valid <= 1'b1;
			i_word_data  <= words[w];
			tries = 0;
			@(negedge clk_sys);
			while (!o_word_ready && tries < 20) begin
				@(negedge clk_sys);
				tries++;
			end
			if (!o_word_ready)
				note_error("host port never became ready");
			// Word moves on this edge
			@(posedge clk_sys);
		end
		i_word_valid <= 1'b0;
		i_cmd_active <= 1'b0;
	endtask

	// Runs whole frames, checking outputs at each falling edge
	task automatic run_frames(input int n_frames, input bit act_low, input bit chk,
			input bit csync_on, input int mark_from);
		logic h;
		logic v;
		logic d;
		int   diff_cnt;
		int   mark_lines;
		int   exp_line;
		exp_line = frame_lines - 1 - mark_ofs;
		for (int f = 0; f < n_frames; f++) begin
			mark_lines = 0;
			for (int ln = 0; ln < frame_lines; ln++) begin
				diff_cnt = 0;
				for (int c = 0; c < line_len; c++) begin
					h = (c < pulse_len);
					v = (ln < V_LINES);
					d = (ln >= 3) && (ln < frame_lines - 2) &&
						(c >= pulse_len + 4) && (c < line_len - 4);
					@(posedge clk_sys);
					i_hsync <= h ^ act_low;
					i_vsync <= v ^ act_low;
					i_de    <= d;
					@(negedge clk_sys);
					if (chk) begin
						compare("o_vsync", 32'(prev_v), 32'(o_vsync));
						if (!csync_on || !prev_v)
							compare("o_hsync", 32'(prev_h), 32'(o_hsync));
						else if (o_hsync != prev_h)
							diff_cnt++;
					end
					// Marker follows the edge seen one cycle into the line
					if (f >= mark_from && c > 0) begin
						compare("o_line_mark", 32'(ln == exp_line), 32'(o_line_mark));
						if (c == 1 && o_line_mark)
							mark_lines++;
					end
					prev_h = h;
					prev_v = v;
				end
				if (chk && csync_on && ln < V_LINES && diff_cnt == 0)
					note_error("composite hsync never differed from plain hsync in a vsync line");
			end
			if (f >= mark_from)
				compare("marked lines per frame", 32'd1, mark_lines);
		end
	endtask

	////////////////////
	// Tests

	task automatic reset_handshake();
		begin_test("reset_handshake");
		@(posedge clk_sys);
		@(negedge clk_sys);
		compare("o_word_ready in reset", 32'd0, 32'(o_word_ready));
		while (resetd)
			@(negedge clk_sys);
		compare("o_hsync", 32'd0, 32'(o_hsync));
		compare("o_vsync", 32'd0, 32'(o_vsync));
		compare("o_line_mark", 32'd0, 32'(o_line_mark));
		@(negedge clk_sys);
		compare("o_word_ready after reset", 32'd1, 32'(o_word_ready));
		finish_test();
	endtask

	task automatic invert_active_low();
		begin_test("polarity_fix");
		run_frames(2, 1'b1, 1'b0, 1'b0, NO_MARK);
		run_frames(1, 1'b1, 1'b1, 1'b0, NO_MARK);
		finish_test();
	endtask

	task automatic pass_active_high();
		begin_test("pass_through");
		run_frames(2, 1'b0, 1'b0, 1'b0, NO_MARK);
		run_frames(1, 1'b0, 1'b1, 1'b0, NO_MARK);
		finish_test();
	endtask

	task automatic toggle_csync();
		begin_test("csync_config");
		send_cmd(OP_CFG, WORD_W'(1 << CFG_CSYNC_BIT));
		run_frames(2, 1'b0, 1'b1, 1'b1, NO_MARK);
		send_cmd(OP_CFG, WORD_W'(0));
		run_frames(2, 1'b0, 1'b1, 1'b0, NO_MARK);
		finish_test();
	endtask

	task automatic mark_programmed_line();
		begin_test("line_marker");
		send_cmd(OP_VS_LINE, WORD_W'(mark_ofs));
		run_frames(3, 1'b0, 1'b1, 1'b0, 1);
		finish_test();
	endtask

	task automatic ignore_unknown_opcode();
		begin_test("unknown_opcode");
		send_cmd(8'h55, 16'hffff);
		run_frames(2, 1'b0, 1'b1, 1'b0, 0);
		finish_test();
	endtask

	////////////////////
	// Main sequence

	initial begin
		void'($urandom(32'h11e6));
		line_len    = 40 + $urandom % 24;
		pulse_len   = 4 + $urandom % 5;
		frame_lines = 10 + $urandom % 6;
		mark_ofs    = 1 + $urandom % (frame_lines - 2);
		i_cmd_active <= 1'b0;
		i_word_valid <= 1'b0;
		i_word_data  <= '0;
		i_hsync      <= 1'b0;
		i_vsync      <= 1'b0;
		i_de         <= 1'b0;
		prev_h    = 1'b0;
		prev_v    = 1'b0;
		errors    = 0;
		tests_run = 0;
		$display("Line %0d cycles, pulse %0d, %0d lines per frame, marker offset %0d",
			line_len, pulse_len, frame_lines, mark_ofs);

		reset_handshake();
		invert_active_low();
		pass_active_high();
		toggle_csync();
		mark_programmed_line();
		ignore_unknown_opcode();

		$display("Tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Twice the frame time of all tests plus slack for commands and reset
	initial begin : watchdog
		int limit;
		#1;
		limit = 2 * (TOTAL_FRAMES * line_len * frame_lines + 200);
		repeat (limit) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, the tests did not complete", limit);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// 20 ns clock and a synchronous reset for the testbench
// Reset is released on a rising edge, so the DUT sees it on exactly 8 edges

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_NS      = 10,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_sys,
	output logic resetd
);

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_NS) clk_sys = ~clk_sys;
	end

	initial begin
		resetd = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		resetd <= 1'b0;
	end

endmodule

`default_nettype wire

//--- sync_shaper.sv
// Video sync conditioner top level, single clock clk_sys
// Raw syncs may have either polarity, outputs are active-high
// Host stream never stalls except in the cycle after reset

`timescale 1ns/1ps
`default_nettype none

module sync_shaper #(
	parameter int CNT_W = 16
) (
	input  wire                                clk_sys,
	input  wire                                resetd,

	// Host word stream
	input  wire                                i_cmd_active,
	input  wire                                i_word_valid,
	input  wire [sync_shaper_pkg::WORD_W-1:0]  i_word_data,
	output logic                               o_word_ready,

	// Video in
	input  wire                                i_hsync,
	input  wire                                i_vsync,
	input  wire                                i_de,

	// Video out
	output logic                               o_hsync,
	output logic                               o_vsync,
	output logic                               o_line_mark
);

	import sync_shaper_pkg::*;

	logic [NUM_SYNC-1:0] sync_raw;
	logic [NUM_SYNC-1:0] sync_fixed;
	logic                csync_en;
	logic [LINE_W-1:0]   vs_line;

	assign sync_raw[SYNC_H] = i_hsync;
	assign sync_raw[SYNC_V] = i_vsync;

	host_cmd_decoder u_dec (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_cmd_active (i_cmd_active),
		.i_word_valid (i_word_valid),
		.i_word_data  (i_word_data),
		.o_word_ready (o_word_ready),
		.o_csync_en   (csync_en),
		.o_vs_line    (vs_line)
	);

	////////////////////
	// Polarity fixers

	for (genvar g = 0; g < NUM_SYNC; g++) begin : g_fix
		sync_polarity_fix #(
			.CNT_W (CNT_W)
		) u_fix (
			.clk_sys (clk_sys),
			.resetd  (resetd),
			.i_sync  (sync_raw[g]),
			.o_sync  (sync_fixed[g])
		);
	end

	csync_gen #(
		.CNT_W (CNT_W)
	) u_csync (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_sync_fixed (sync_fixed),
		.i_csync_en   (csync_en),
		.o_hsync      (o_hsync),
		.o_vsync      (o_vsync)
	);

	line_mark_gen u_mark (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_hsync_fixed (sync_fixed[SYNC_H]),
		.i_de          (i_de),
		.i_vs_line     (vs_line),
		.o_line_mark   (o_line_mark)
	);

endmodule

`default_nettype wire

//--- line_mark_gen.sv
// Once-per-frame line marker at a host-programmed offset from the frame end
// Frame restart is the second hsync rising edge after the last active DE
// Marker is updated at hsync rising edges only

`timescale 1ns/1ps
`default_nettype none

module line_mark_gen (
	input  wire                                clk_sys,
	input  wire                                resetd,
	input  wire                                i_hsync_fixed,
	input  wire                                i_de,
	input  wire [sync_shaper_pkg::LINE_W-1:0]  i_vs_line,
	output logic                               o_line_mark
);

	import sync_shaper_pkg::*;

	logic              hs_q;
	logic              hs_rise;
	logic [LINE_W-1:0] line_cnt;
	logic [LINE_W-1:0] target;
	logic [1:0]        blank_edges;

	assign hs_rise = i_hsync_fixed & ~hs_q;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hs_q        <= 1'b0;
			line_cnt    <= '0;
			target      <= '0;
			blank_edges <= '0;
			o_line_mark <= 1'b0;
		end else begin
			hs_q <= i_hsync_fixed;

			if (hs_rise) begin
				o_line_mark <= (target == line_cnt);
				line_cnt    <= line_cnt + 1'b1;

				// Count edges in blanking, stop after the restart edge
				if (!blank_edges[1]) begin
					blank_edges <= blank_edges + 1'b1;
					if (blank_edges[0]) begin
						target   <= line_cnt - i_vs_line;
						line_cnt <= '0;
					end
				end
			end

			if (i_de)
				blank_edges <= '0;
		end
	end

	a_mark_on_hs_edge: assert property (
		@(posedge clk_sys) disable iff (resetd)
		$changed(o_line_mark) |-> ($past(i_hsync_fixed) && !$past(i_hsync_fixed, 2))
	);

endmodule

`default_nettype wire

//--- csync_gen.sv
// Composite sync from the active-high horizontal and vertical syncs
// Both outputs lag the fixed syncs by one cycle
// Line length is learnt from the previous line, so the first vsync line may be off

`timescale 1ns/1ps
`default_nettype none

module csync_gen #(
	parameter int CNT_W = 16
) (
	input  wire                                  clk_sys,
	input  wire                                  resetd,
	input  wire [sync_shaper_pkg::NUM_SYNC-1:0]  i_sync_fixed,
	input  wire                                  i_csync_en,
	output logic                                 o_hsync,
	output logic                                 o_vsync
);

	import sync_shaper_pkg::*;

	logic             hs;
	logic             vs;
	logic             hs_q;
	logic             vs_q;
	logic             csync_hs;
	logic [CNT_W-1:0] h_cnt;
	logic [CNT_W-1:0] line_len;
	logic [CNT_W-1:0] hs_len;

	assign hs = i_sync_fixed[SYNC_H];
	assign vs = i_sync_fixed[SYNC_V];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hs_q     <= 1'b0;
			vs_q     <= 1'b0;
			csync_hs <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else begin
			hs_q  <= hs;
			vs_q  <= vs;
			h_cnt <= h_cnt + 1'b1;

			////////////////////
			// Line and pulse length
			if (hs != hs_q) begin
				h_cnt <= '0;
				if (hs)
					line_len <= h_cnt - hs_len;
				else
					hs_len <= h_cnt;
			end

			// During vsync the pulse moves ahead by its own width
			if (!vs)
				csync_hs <= hs;
			else if (hs && !hs_q)
				csync_hs <= 1'b0;
			else if (h_cnt == line_len)
				csync_hs <= 1'b1;
		end
	end

	assign o_vsync = vs_q;
	assign o_hsync = i_csync_en ? (vs_q ^ csync_hs) : hs_q;

endmodule

`default_nettype wire

//--- sync_polarity_fix.sv
// Makes one sync active-high by comparing its high and low phase lengths
// Output follows the input with no delay, polarity decided after both phases
// Phases longer than 2**CNT_W cycles are not supported

`timescale 1ns/1ps
`default_nettype none

module sync_polarity_fix #(
	parameter int CNT_W = 16
) (
	input  wire  clk_sys,
	input  wire  resetd,
	input  wire  i_sync,
	output logic o_sync
);

	logic             s1;
	logic             s2;
	logic             edge_seen;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] len_hi;
	logic [CNT_W-1:0] len_lo;
	logic             have_hi;
	logic             have_lo;
	logic             pol;
	logic             wrapped;

	assign edge_seen = s1 ^ s2;
	assign o_sync    = i_sync ^ pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1      <= 1'b0;
			s2      <= 1'b0;
			cnt     <= '0;
			len_hi  <= '0;
			len_lo  <= '0;
			have_hi <= 1'b0;
			have_lo <= 1'b0;
			pol     <= 1'b0;
			wrapped <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;

			if (edge_seen) begin
				cnt     <= '0;
				wrapped <= 1'b0;
				// Rising edge closes a low phase, falling edge a high one
				if (s1) begin
					len_lo  <= cnt;
					have_lo <= 1'b1;
				end else begin
					len_hi  <= cnt;
					have_hi <= 1'b1;
				end
			end else begin
				cnt <= cnt + 1'b1;
				if (&cnt && have_hi && have_lo)
					wrapped <= 1'b1;
			end

			// Longer high phase means the pulse is the low one
			pol <= have_hi & have_lo & (len_hi > len_lo);
		end
	end

	// Once toggling, every phase must end before the counter rolls over
	a_no_wrap: assert property (
		@(posedge clk_sys) disable iff (resetd) edge_seen |-> !wrapped
	);

endmodule

`default_nettype wire

//--- host_cmd_decoder.sv
// Host word decoder for OP_CFG and OP_VS_LINE
// Ready is low for one cycle after reset and high at all other times
// First word of a frame is the opcode, every later word is payload

`timescale 1ns/1ps
`default_nettype none

module host_cmd_decoder (
	input  wire                                   clk_sys,
	input  wire                                   resetd,
	input  wire                                   i_cmd_active,
	input  wire                                   i_word_valid,
	input  wire [sync_shaper_pkg::WORD_W-1:0]     i_word_data,
	output logic                                  o_word_ready,
	output logic                                  o_csync_en,
	output logic [sync_shaper_pkg::LINE_W-1:0]    o_vs_line
);

	import sync_shaper_pkg::*;

	dec_state_e state;
	opcode_e    cmd;
	logic       xfer;

	assign xfer = i_word_valid & o_word_ready;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state        <= ST_OPCODE;
			o_word_ready <= 1'b0;
			o_csync_en   <= 1'b0;
			o_vs_line    <= '0;
		end else begin
			o_word_ready <= 1'b1;

			// Dropping the frame resets the opcode slot
			if (!i_cmd_active) begin
				state <= ST_OPCODE;
			end else if (xfer) begin
				case (state)
					ST_OPCODE: begin
						cmd   <= opcode_e'(i_word_data[7:0]);
						state <= ST_PAYLOAD;
					end
					ST_PAYLOAD: begin
						case (cmd)
							OP_CFG:     o_csync_en <= i_word_data[CFG_CSYNC_BIT];
							OP_VS_LINE: o_vs_line  <= i_word_data[LINE_W-1:0];
							// Unknown opcodes swallow their payload
							default: ;
						endcase
					end
					default: state <= ST_OPCODE;
				endcase
			end
		end
	end

	////////////////////
	// Checks

	// No word may be taken in the cycle that follows a reset cycle
	a_ready_low_after_reset: assert property (
		@(posedge clk_sys) resetd |=> !o_word_ready
	);

endmodule

`default_nettype wire

//--- sync_shaper_pkg.sv
// Shared widths, channel indices and enums for the sync conditioner
// Host words are 16 bits, and only the low 8 bits of an opcode word count
// Line numbers wrap at 12 bits, so frames must stay under 4096 lines

`default_nettype none

package sync_shaper_pkg;

	////////////////////
	// Widths

	localparam int WORD_W = 16;
	localparam int LINE_W = 12;

	////////////////////
	// Sync channels

	localparam int NUM_SYNC = 2;
	localparam int SYNC_H   = 0;
	localparam int SYNC_V   = 1;

	// Composite enable within the OP_CFG payload
	localparam int CFG_CSYNC_BIT = 3;

	////////////////////
	// Host command set

	typedef enum logic [7:0] {
		OP_CFG     = 8'h01,
		OP_VS_LINE = 8'h38
	} opcode_e;

	typedef enum logic {
		ST_OPCODE  = 1'b0,
		ST_PAYLOAD = 1'b1
	} dec_state_e;

endpackage

`default_nettype wire
